//--- hw/spr_defines.svh
//**************************************************************************
// Build-time feature set, version numbers and SPR numbers of the SPR unit.
// Feature switches are one bit, 1 when the unit exists in the core.
// The IMMU has no geometry of its own and reports the DMMU TLB geometry.
// Way counts must be powers of two.
//**************************************************************************

`ifndef SPR_DEFINES_SVH
`define SPR_DEFINES_SVH

// Optional units
`define FEATURE_DCACHE 1'b1
`define FEATURE_ICACHE 1'b1
`define FEATURE_DMMU 1'b1
`define FEATURE_IMMU 1'b0
`define FEATURE_FPU 1'b0
`define FEATURE_EVBAR 1'b1

// Cache and TLB geometry, set width in log2 of sets
`define DCACHE_SET_WIDTH 9
`define DCACHE_WAYS 2
`define ICACHE_SET_WIDTH 9
`define ICACHE_WAYS 2
`define DMMU_SET_WIDTH 6
`define DMMU_WAYS 1

// Implementation identity, ends up in VR2
`define CPU_VER_MAJOR 8'd5
`define CPU_VER_MINOR 8'd0
`define CPUID 8'h01

// SPR numbers, group 0
`define SPR_ADDR_VR 16'h0000
`define SPR_ADDR_UPR 16'h0001
`define SPR_ADDR_CPUCFGR 16'h0002
`define SPR_ADDR_DMMUCFGR 16'h0003
`define SPR_ADDR_IMMUCFGR 16'h0004
`define SPR_ADDR_DCCFGR 16'h0005
`define SPR_ADDR_ICCFGR 16'h0006
`define SPR_ADDR_VR2 16'h0009
`define SPR_ADDR_AVR 16'h000a
`define SPR_ADDR_SR 16'h0011
`define SPR_ADDR_EPCR 16'h0020
`define SPR_ADDR_EEAR 16'h0030
`define SPR_ADDR_ESR 16'h0040

// SR layout
`define SR_SM_BIT 0 // Supervisor mode
`define SR_FO_BIT 15 // Fixed one
`define SR_WRITE_MASK 32'h0000_7fff // FO and upper bits read-only
`define SR_RESET 32'h0000_8001 // SM and FO set

`endif

//--- hw/spr_pkg.sv
//**************************************************************************
// Types shared by the SPR unit and the core side.
// Packed structs, first field sits in the MSBs.
//**************************************************************************

`default_nettype none

package spr_pkg;

   typedef logic [15:0] spr_addr_t; // SPR number, group and index
   typedef logic [31:0] spr_data_t;

   // Which supervision register a granted write targets
   typedef enum logic [1:0] {
      SYS_SR,
      SYS_EPCR,
      SYS_EEAR,
      SYS_ESR
   } sys_sel_t;

   typedef struct packed {
      logic re; // One-cycle strobes, never both
      logic we;
      spr_addr_t addr;
      spr_data_t wdata;
   } spr_req_t;

   typedef struct packed {
      logic ack;
      logic err; // Privilege refusal
      spr_data_t rdata; // Zero unless ack
   } spr_rsp_t;

   // Read-only words, fixed at build
   typedef struct packed {
      spr_data_t vr;
      spr_data_t upr;
      spr_data_t cpucfgr;
      spr_data_t dmmucfgr;
      spr_data_t immucfgr;
      spr_data_t dccfgr;
      spr_data_t iccfgr;
      spr_data_t vr2;
      spr_data_t avr;
   } spr_cfg_t;

   typedef struct packed {
      spr_data_t sr;
      spr_data_t epcr;
      spr_data_t eear;
      spr_data_t esr;
   } spr_sys_t;

   typedef struct packed {
      logic valid; // Already privilege-checked
      sys_sel_t sel;
      spr_data_t data;
   } spr_wr_t;

   typedef struct packed {
      logic enter; // One-cycle pulse
      spr_data_t pc;
      spr_data_t eear;
   } exc_t;

endpackage

`default_nettype wire

//--- hw/spr_cfgrs.sv
//**************************************************************************
// Configuration and version words, pure combinational constants.
// Absent units give all-zero fields. Cache block size is reported as
// 16 bytes, PIC, timer, debug and MAC as absent.
//**************************************************************************

`include "spr_defines.svh"
`default_nettype none
`timescale 1ns/1ns

module spr_cfgrs
   import spr_pkg::*;
(
   output spr_cfg_t cfg
);

   // DCCFGR/ICCFGR share a layout, only DCCFGR has CBFRI
   function automatic spr_data_t cache_cfgr(input logic present,
                                            input logic has_flush,
                                            input int unsigned set_width,
                                            input int unsigned ways);
      spr_data_t w;
      w = '0;
      if (present) begin
         w[2:0] = 3'($clog2(ways)); // NCW, log2 of ways
         w[6:3] = 4'(set_width); // NCS
         w[10] = 1'b1; // CBIRI
         w[13] = has_flush; // CBFRI
      end
      return w;
   endfunction

   // DMMUCFGR/IMMUCFGR, no ATB, no control or protection regs
   function automatic spr_data_t mmu_cfgr(input logic present,
                                          input int unsigned set_width,
                                          input int unsigned ways);
      spr_data_t w;
      w = '0;
      if (present) begin
         w[1:0] = 2'($clog2(ways)); // NTW
         w[4:2] = 3'(set_width); // NTS
      end
      return w;
   endfunction

   always_comb begin
      cfg = '0;

      // VR, legacy version with UVRP pointing at VR2
      cfg.vr[31:24] = 8'h10;
      cfg.vr[6] = 1'b1;

      cfg.upr[0] = 1'b1; // UPR itself present
      cfg.upr[1] = `FEATURE_DCACHE;
      cfg.upr[2] = `FEATURE_ICACHE;
      cfg.upr[3] = `FEATURE_DMMU;
      cfg.upr[4] = `FEATURE_IMMU;

      // CPUCFGR
      cfg.cpucfgr[5] = 1'b1; // ORBIS32
      cfg.cpucfgr[7] = `FEATURE_FPU; // ORFPX32
      cfg.cpucfgr[10] = 1'b1; // No delay slot
      cfg.cpucfgr[11] = 1'b1; // AVR always there
      cfg.cpucfgr[12] = `FEATURE_EVBAR;

      cfg.dmmucfgr = mmu_cfgr(`FEATURE_DMMU, `DMMU_SET_WIDTH, `DMMU_WAYS);
      // IMMU borrows DMMU geometry
      cfg.immucfgr = mmu_cfgr(`FEATURE_IMMU, `DMMU_SET_WIDTH, `DMMU_WAYS);

      cfg.dccfgr = cache_cfgr(`FEATURE_DCACHE, 1'b1, `DCACHE_SET_WIDTH, `DCACHE_WAYS);
      cfg.iccfgr = cache_cfgr(`FEATURE_ICACHE, 1'b0, `ICACHE_SET_WIDTH, `ICACHE_WAYS);

      // VR2 is CPUID, major, minor, pipeline id left zero
      cfg.vr2 = {`CPUID, `CPU_VER_MAJOR, `CPU_VER_MINOR, 8'd0};

      // Architecture 1.1 rev 0
      cfg.avr[31:24] = 8'd1;
      cfg.avr[23:16] = 8'd1;
      cfg.avr[15:8] = 8'd0;
   end

endmodule

`default_nettype wire

//--- hw/spr_sysregs.sv
//**************************************************************************
// Supervision registers SR, EPCR, EEAR and ESR.
// Writes arrive pre-checked from the access block. Exception entry wins
// over a same-cycle write, which is then lost. SR bits outside
// SR_WRITE_MASK keep their reset value, so FO stays 1.
//**************************************************************************

`include "spr_defines.svh"
`default_nettype none
`timescale 1ns/1ns

module spr_sysregs
   import spr_pkg::*;
(
   input wire logic clk,
   input wire logic rst_n,
   input wire spr_wr_t wr,
   input wire exc_t exc,
   output spr_sys_t sys
);

   spr_data_t sr_masked; // SR after a software write
   spr_data_t sr_exc; // SR on exception entry

   // Only writable bits come from the core
   assign sr_masked = (sys.sr & ~`SR_WRITE_MASK) | (wr.data & `SR_WRITE_MASK);

   always_comb begin
      sr_exc = sys.sr;
      sr_exc[`SR_SM_BIT] = 1'b1; // Handler runs supervised
   end

   always_ff @(posedge clk) begin
      if (!rst_n) begin
         sys.sr <= `SR_RESET;
         sys.epcr <= '0;
         sys.eear <= '0;
         sys.esr <= '0;
      end else if (exc.enter) begin
         // Entry, any write this cycle is dropped
         sys.esr <= sys.sr; // Old SR, before SM forced
         sys.epcr <= exc.pc;
         sys.eear <= exc.eear;
         sys.sr <= sr_exc;
      end else if (wr.valid) begin
         case (wr.sel)
            SYS_SR: sys.sr <= sr_masked;
            SYS_EPCR: sys.epcr <= wr.data;
            SYS_EEAR: sys.eear <= wr.data;
            SYS_ESR: sys.esr <= wr.data; // Full word, restored by rfe
            default: ;
         endcase
      end
   end

endmodule

`default_nettype wire

//--- hw/spr_access.sv
//**************************************************************************
// SPR access path: decode, privilege check, read mux, response register.
// Ack comes exactly one cycle after re or we. User-mode accesses get
// err and no effect. Unknown addresses read 0, writes to them and to
// config words are acked and dropped.
//**************************************************************************

`include "spr_defines.svh"
`default_nettype none
`timescale 1ns/1ns

module spr_access
   import spr_pkg::*;
(
   input wire logic clk,
   input wire logic rst_n,
   input wire spr_req_t req,
   input wire spr_cfg_t cfg,
   input wire spr_sys_t sys,
   output spr_wr_t wr,
   output spr_rsp_t rsp
);

   spr_data_t rd_word; // Decoded read value
   logic sys_hit; // Address is a writable supervision reg
   sys_sel_t sys_sel;
   logic priv_ok; // Supervisor mode
   logic strobe;

   assign priv_ok = sys.sr[`SR_SM_BIT];
   assign strobe = req.re | req.we;

   // Address decode and read mux
   always_comb begin
      rd_word = '0; // Unknown reads as zero
      sys_hit = 1'b0;
      sys_sel = SYS_SR;
      case (req.addr)
         `SPR_ADDR_VR: rd_word = cfg.vr;
         `SPR_ADDR_UPR: rd_word = cfg.upr;
         `SPR_ADDR_CPUCFGR: rd_word = cfg.cpucfgr;
         `SPR_ADDR_DMMUCFGR: rd_word = cfg.dmmucfgr;
         `SPR_ADDR_IMMUCFGR: rd_word = cfg.immucfgr;
         `SPR_ADDR_DCCFGR: rd_word = cfg.dccfgr;
         `SPR_ADDR_ICCFGR: rd_word = cfg.iccfgr;
         `SPR_ADDR_VR2: rd_word = cfg.vr2;
         `SPR_ADDR_AVR: rd_word = cfg.avr;
         `SPR_ADDR_SR: begin
            rd_word = sys.sr;
            sys_hit = 1'b1;
         end
         `SPR_ADDR_EPCR: begin
            rd_word = sys.epcr;
            sys_hit = 1'b1;
            sys_sel = SYS_EPCR;
         end
         `SPR_ADDR_EEAR: begin
            rd_word = sys.eear;
            sys_hit = 1'b1;
            sys_sel = SYS_EEAR;
         end
         `SPR_ADDR_ESR: begin
            rd_word = sys.esr;
            sys_hit = 1'b1;
            sys_sel = SYS_ESR;
         end
         default: ;
      endcase
   end

   // Granted write, applied by sysregs at this edge
   assign wr.valid = req.we & priv_ok & sys_hit;
   assign wr.sel = sys_sel;
   assign wr.data = req.wdata;

   // Response one cycle later, read sees pre-write value
   always_ff @(posedge clk) begin
      if (!rst_n) begin
         rsp <= '0;
      end else begin
         rsp.ack <= strobe;
         rsp.err <= strobe & ~priv_ok; // Refused in user mode
         rsp.rdata <= (req.re & priv_ok) ? rd_word : '0;
      end
   end

endmodule

`default_nettype wire

//--- hw/spr_unit.sv
//**************************************************************************
// SPR unit top. Plain re/we strobes in, one-cycle ack out.
// sys goes back to the core for the mode bit and exception return.
//**************************************************************************

`default_nettype none
`timescale 1ns/1ns

module spr_unit
   import spr_pkg::*;
(
   input wire logic clk,
   input wire logic rst_n,
   input wire spr_req_t req,
   input wire exc_t exc,
   output spr_rsp_t rsp,
   output spr_sys_t sys
);

   spr_cfg_t cfg; // Build-time constants
   spr_wr_t wr; // Granted write

   spr_cfgrs u_cfgrs (
      .cfg (cfg)
   );

   // Supervision regs, SM bit feeds the access check
   spr_sysregs u_sysregs (
      .clk (clk),
      .rst_n (rst_n),
      .wr (wr),
      .exc (exc),
      .sys (sys)
   );

   spr_access u_access (
      .clk (clk),
      .rst_n (rst_n),
      .req (req),
      .cfg (cfg),
      .sys (sys),
      .wr (wr),
      .rsp (rsp)
   );

endmodule

`default_nettype wire

//--- test/tb_clock.sv
//**************************************************************************
// Testbench clock and reset, 10 ns period.
// rst_n is low for the first 4 rising edges, released on a falling edge.
//**************************************************************************

`default_nettype none
`timescale 1ns/1ns

module tb_clock (
   output logic clk,
   output logic rst_n
);

   initial begin
      clk = 1'b0;
      forever #5 clk = ~clk; // 10 ns period
   end

   initial begin
      rst_n = 1'b0;
      repeat (4) @(posedge clk);
      @(negedge clk);
      rst_n = 1'b1; // Clear of the sampling edge
   end

endmodule

`default_nettype wire

//--- test/spr_assert.sv
//**************************************************************************
// Protocol checks on the SPR access path, bound into spr_access.
// All properties are off while rst_n is low.
//**************************************************************************

`default_nettype none
`timescale 1ns/1ns

module spr_assert
   import spr_pkg::*;
(
   input wire logic clk,
   input wire logic rst_n,
   input wire spr_req_t req,
   input wire spr_rsp_t rsp
);

   logic strobe;

   assign strobe = req.re | req.we;

   // Core never raises both strobes
   a_one_strobe: assert property (@(posedge clk) disable iff (!rst_n) !(req.re && req.we))
      else $error("re and we high in the same cycle");

   a_ack_after_strobe: assert property (@(posedge clk) disable iff (!rst_n) strobe |=> rsp.ack)
      else $error("no ack one cycle after a strobe");

   // No ack without a strobe before it
   a_no_stray_ack: assert property (@(posedge clk) disable iff (!rst_n) !strobe |=> !rsp.ack)
      else $error("ack without a strobe one cycle before");

   a_err_with_ack: assert property (@(posedge clk) disable iff (!rst_n) rsp.err |-> rsp.ack)
      else $error("err high while ack is low");

endmodule

bind spr_access spr_assert u_assert (
   .clk (clk),
   .rst_n (rst_n),
   .req (req),
   .rsp (rsp)
);

`default_nettype wire

//--- test/spr_tb.sv
//**************************************************************************
// SPR unit testbench. Directed reads of every known SPR after reset, then
// random reads, writes and exception pulses from an LCG with a fixed seed.
// A model of SR, EPCR, EEAR and ESR predicts each response and sys.
// Inputs change on the falling edge, results are checked there too.
//**************************************************************************

`include "spr_defines.svh"
`default_nettype none
`timescale 1ns/1ns

module spr_tb
   import spr_pkg::*;
();

   localparam int N_TXN = 2000;
   localparam int N_KNOWN = 13;
   localparam int TIMEOUT_CYCLES = 2500; // Txns, 1/16 idle slots, reset

   logic clk;
   logic rst_n;
   spr_req_t req;
   exc_t exc;
   spr_rsp_t rsp;
   spr_sys_t sys;

   spr_sys_t model_sys; // State after the next rising edge
   logic pend_ack; // Expected response for the strobe in flight
   logic pend_err;
   spr_data_t pend_rdata;
   logic [31:0] rng_state;
   int cycle_count;
   spr_addr_t known_addrs [0:N_KNOWN-1];

   tb_clock u_clock (
      .clk (clk),
      .rst_n (rst_n)
   );

   spr_unit DUT (
      .clk (clk),
      .rst_n (rst_n),
      .req (req),
      .exc (exc),
      .rsp (rsp),
      .sys (sys)
   );

   function automatic logic [31:0] next_rand();
      rng_state = rng_state * 32'd1664525 + 32'd1013904223;
      return rng_state;
   endfunction

   // Config words straight from the feature macros
   function automatic spr_data_t expected_cfg(input spr_addr_t addr);
      case (addr)
         `SPR_ADDR_VR: return 32'h1000_0040; // Version 0x10, UVRP
         `SPR_ADDR_UPR: return {27'd0, `FEATURE_IMMU, `FEATURE_DMMU,
                                `FEATURE_ICACHE, `FEATURE_DCACHE, 1'b1};
         `SPR_ADDR_CPUCFGR: return 32'h0000_0c20 | (32'(`FEATURE_FPU) << 7)
                                   | (32'(`FEATURE_EVBAR) << 12);
         `SPR_ADDR_DMMUCFGR: return `FEATURE_DMMU ?
            ((32'(`DMMU_SET_WIDTH) << 2) | 32'($clog2(`DMMU_WAYS))) : 32'd0;
         `SPR_ADDR_IMMUCFGR: return `FEATURE_IMMU ?
            ((32'(`DMMU_SET_WIDTH) << 2) | 32'($clog2(`DMMU_WAYS))) : 32'd0;
         `SPR_ADDR_DCCFGR: return `FEATURE_DCACHE ? (32'h0000_2400
            | (32'(`DCACHE_SET_WIDTH) << 3) | 32'($clog2(`DCACHE_WAYS))) : 32'd0;
         `SPR_ADDR_ICCFGR: return `FEATURE_ICACHE ? (32'h0000_0400
            | (32'(`ICACHE_SET_WIDTH) << 3) | 32'($clog2(`ICACHE_WAYS))) : 32'd0;
         `SPR_ADDR_VR2: return {`CPUID, `CPU_VER_MAJOR, `CPU_VER_MINOR, 8'd0};
         `SPR_ADDR_AVR: return 32'h0101_0000; // Arch 1.1 rev 0
         default: return 32'd0; // Unknown reads as zero
      endcase
   endfunction

   function automatic spr_data_t model_read(input spr_addr_t addr);
      case (addr)
         `SPR_ADDR_SR: return model_sys.sr;
         `SPR_ADDR_EPCR: return model_sys.epcr;
         `SPR_ADDR_EEAR: return model_sys.eear;
         `SPR_ADDR_ESR: return model_sys.esr;
         default: return expected_cfg(addr);
      endcase
   endfunction

   task automatic stop_run();
      $display("ERRORS FOUND");
      $fatal(1, "stopped at the first error");
   endtask

   task automatic check_data(input string name, input spr_data_t got, input spr_data_t exp);
      if (got !== exp) begin
         $display("FAIL %s got %h exp %h", name, got, exp);
         stop_run();
      end
   endtask

   task automatic check_flag(input string name, input logic got, input logic exp);
      if (got !== exp) begin
         $display("FAIL %s got %h exp %h", name, got, exp);
         stop_run();
      end
   endtask

   task automatic check_sys(input spr_sys_t got, input spr_sys_t exp);
      check_data("sys.sr", got.sr, exp.sr);
      check_data("sys.epcr", got.epcr, exp.epcr);
      check_data("sys.eear", got.eear, exp.eear);
      check_data("sys.esr", got.esr, exp.esr);
   endtask

   // Response to the last strobe, state after the last edge
   task automatic check_response();
      check_flag("rsp.ack", rsp.ack, pend_ack);
      check_flag("rsp.err", rsp.err, pend_err);
      check_data("rsp.rdata", rsp.rdata, pend_rdata);
      check_sys(sys, model_sys);
   endtask

   // Predict the response and the next state, then drive the inputs
   task automatic issue(input logic re, input logic we, input spr_addr_t addr,
                        input spr_data_t wdata, input logic enter,
                        input spr_data_t pc, input spr_data_t ea);
      logic sm;
      sm = model_sys.sr[`SR_SM_BIT];
      pend_ack = re | we;
      pend_err = (re | we) & ~sm; // User mode refused
      pend_rdata = (re && sm) ? model_read(addr) : 32'd0; // Pre-write value
      if (enter) begin
         model_sys.esr = model_sys.sr; // Old SR first
         model_sys.epcr = pc;
         model_sys.eear = ea;
         model_sys.sr[`SR_SM_BIT] = 1'b1;
      end else if (we && sm) begin
         case (addr)
            `SPR_ADDR_SR: model_sys.sr = (model_sys.sr & ~`SR_WRITE_MASK)
                                         | (wdata & `SR_WRITE_MASK);
            `SPR_ADDR_EPCR: model_sys.epcr = wdata;
            `SPR_ADDR_EEAR: model_sys.eear = wdata;
            `SPR_ADDR_ESR: model_sys.esr = wdata;
            default: ; // Config and unknown, no effect
         endcase
      end
      req.re = re;
      req.we = we;
      req.addr = addr;
      req.wdata = wdata;
      exc.enter = enter;
      exc.pc = pc;
      exc.eear = ea;
   endtask

   always @(posedge clk) begin
      cycle_count <= cycle_count + 1;
      if (cycle_count >= TIMEOUT_CYCLES) begin
         $display("Timeout, run did not finish within %0d cycles", TIMEOUT_CYCLES);
         stop_run();
      end
   end

   initial begin
      logic [31:0] r;
      spr_addr_t addr;
      spr_data_t wdata;
      spr_data_t pc;
      spr_data_t ea;
      int n;
      cycle_count = 0;
      rng_state = 32'h938ad31a;
      req = '0;
      exc = '0;
      model_sys = '0;
      model_sys.sr = `SR_RESET;
      pend_ack = 1'b0;
      pend_err = 1'b0;
      pend_rdata = '0;
      known_addrs = '{`SPR_ADDR_VR, `SPR_ADDR_UPR, `SPR_ADDR_CPUCFGR,
                      `SPR_ADDR_DMMUCFGR, `SPR_ADDR_IMMUCFGR, `SPR_ADDR_DCCFGR,
                      `SPR_ADDR_ICCFGR, `SPR_ADDR_VR2, `SPR_ADDR_AVR,
                      `SPR_ADDR_SR, `SPR_ADDR_EPCR, `SPR_ADDR_EEAR, `SPR_ADDR_ESR};
      wait (rst_n === 1'b1);
      n = 0;
      while (n < N_TXN) begin
         @(negedge clk);
         check_response();
         r = next_rand();
         wdata = next_rand();
         pc = next_rand();
         ea = next_rand();
         if (n < N_KNOWN) begin
            issue(1'b1, 1'b0, known_addrs[n], '0, 1'b0, '0, '0); // Reset values
            n++;
         end else if (r[7:4] == 4'd0) begin
            issue(1'b0, 1'b0, '0, '0, 1'b0, '0, '0); // Idle slot
         end else begin
            if (r[23:22] == 2'd0)
               addr = spr_addr_t'(next_rand()); // Mostly unknown
            else
               addr = known_addrs[int'(r[15:8]) % N_KNOWN];
            // Exception about 1 in 16, any strobe alongside
            issue(~r[31], r[31], addr, wdata, r[27:24] == 4'hf, pc, ea);
            n++;
         end
      end
      @(negedge clk);
      check_response();
      issue(1'b0, 1'b0, '0, '0, 1'b0, '0, '0);
      @(negedge clk);
      check_response(); // Last ack drops
      $display("NO ERRORS");
      $finish;
   end

endmodule

`default_nettype wire

//--- build.f
+incdir+hw
hw/spr_pkg.sv
hw/spr_cfgrs.sv
hw/spr_sysregs.sv
hw/spr_access.sv
hw/spr_unit.sv
test/tb_clock.sv
test/spr_assert.sv
test/spr_tb.sv

//--- run.sh
#!/bin/sh
# Compile and run the SPR unit testbench with Verilator.
# Exit status is nonzero when the run fails.
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert --top-module spr_tb -Mdir obj_dir -f build.f
./obj_dir/Vspr_tb
